/* align_buffer/align_buffer_top.sv */
`timescale 1ns/1ns

module align_buffer_top (
  input  logic                      clk,
  input  logic                      rst_n,

  // Controller
  input  align_pkg::align_ctrl_t    ctrl_i,

  // Instruction memory
  output fetch_bus_pkg::fetch_req_t req_o,
  input  logic                      req_ready_i,
  input  fetch_bus_pkg::fetch_rsp_t rsp_i,

  // Decode stage
  output align_pkg::instr_out_t     instr_o,
  input  logic                      instr_ready_i
);

  import fetch_bus_pkg::*;

  // Response accepted into the buffer (stale words filtered out)
  logic  accept;
  // Instruction handed to decode this cycle
  logic  pop;
  // Head word fully consumed
  logic  advance;

  // Store read side
  word_t head_word;
  logic  head_valid;
  word_t next_word;
  logic  next_valid;

  ////////////////////////////////////////////////////////////
  // Request and credit control
  fetch_credit_ctrl credit0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_i      (ctrl_i),
    .req_o       (req_o),
    .req_ready_i (req_ready_i),
    .rsp_i       (rsp_i),
    .pop_i       (pop),
    .accept_o    (accept)
  );

  ////////////////////////////////////////////////////////////
  // Word storage
  word_store store0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (ctrl_i.redirect),
    .rsp_i        (rsp_i),
    .accept_i     (accept),
    .advance_i    (advance),
    .head_o       (head_word),
    .head_valid_o (head_valid),
    .next_o       (next_word),
    .next_valid_o (next_valid)
  );

  ////////////////////////////////////////////////////////////
  // Alignment towards decode
  instr_aligner aligner0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .rsp_i         (rsp_i),
    .accept_i      (accept),
    .head_i        (head_word),
    .head_valid_i  (head_valid),
    .next_i        (next_word),
    .next_valid_i  (next_valid),
    .instr_o       (instr_o),
    .instr_ready_i (instr_ready_i),
    .pop_o         (pop),
    .advance_o     (advance)
  );

endmodule

/* align_buffer/fetch_credit_ctrl.sv */
`timescale 1ns/1ns
`include "align_params.svh"

module fetch_credit_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  align_pkg::align_ctrl_t    ctrl_i,
  output fetch_bus_pkg::fetch_req_t req_o,
  input  logic                      req_ready_i,
  input  fetch_bus_pkg::fetch_rsp_t rsp_i,
  input  logic                      pop_i,
  output logic                      accept_o
);

  import fetch_bus_pkg::*;
  import align_pkg::*;

  localparam int unsigned CNT_W  = $clog2(`ALIGN_CREDITS + 1);
  // Two instructions per word at most
  localparam int unsigned ICNT_W = $clog2(2 * `ALIGN_DEPTH + 1);

  logic [CNT_W-1:0]  outstanding_q, outstanding_n;
  logic [CNT_W-1:0]  flush_q, flush_n;
  logic [ICNT_W-1:0] instr_cnt_q, instr_cnt_n, instr_cnt_adj;
  logic [1:0]        n_incoming;
  logic              pop_q;
  logic              req_fire;
  fill_state_e       fill_q, fill_n;
  addr_t             target_word;
  addr_t             fetch_addr_q;

  ////////////////////////////////////////////////////////////
  // Request side
  assign target_word   = {ctrl_i.redirect_addr[31:2], 2'b00};
  // Pops reach the count one cycle late
  assign instr_cnt_adj = instr_cnt_q - ICNT_W'(pop_q);

  // Fetch only when the buffer is about to run dry
  assign req_o.valid  = ctrl_i.fetch_enable && (outstanding_q < CNT_W'(`ALIGN_CREDITS)) &&
                        (ctrl_i.redirect || (instr_cnt_adj == '0) ||
                         ((instr_cnt_adj == ICNT_W'(1)) && (outstanding_q == '0)));
  assign req_o.branch = ctrl_i.redirect;
  assign req_o.addr   = ctrl_i.redirect ? target_word : fetch_addr_q;
  assign req_fire     = req_o.valid && req_ready_i;

  // Stale words and words racing a redirect never enter the buffer
  assign accept_o = rsp_i.valid && (flush_q == '0) && !ctrl_i.redirect;

  always_comb begin
    outstanding_n = outstanding_q + CNT_W'(req_fire) - CNT_W'(rsp_i.valid);
    flush_n       = flush_q;
    if (ctrl_i.redirect) begin
      // Everything still in flight belongs to the old stream
      flush_n = outstanding_q - CNT_W'(rsp_i.valid);
    end else if (rsp_i.valid && (flush_q != '0)) begin
      flush_n = flush_q - CNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Complete instructions per accepted word
  always_comb begin
    fill_n     = fill_q;
    n_incoming = 2'd0;
    if (ctrl_i.redirect) begin
      fill_n = ctrl_i.redirect_addr[1] ? UNALIGNED_SKIP : ALIGNED;
    end else if (accept_o) begin
      case (fill_q)
        ALIGNED: begin
          if (rsp_i.word[1:0] == 2'b11) begin
            n_incoming = 2'd1;
          end else if (rsp_i.word[17:16] == 2'b11) begin
            // Upper half opens a split instruction
            n_incoming = 2'd1;
            fill_n     = UNALIGNED_PART;
          end else begin
            n_incoming = 2'd2;
          end
        end
        UNALIGNED_SKIP: begin
          // Lower half lies before the branch target
          if (rsp_i.word[17:16] == 2'b11) begin
            fill_n = UNALIGNED_PART;
          end else begin
            n_incoming = 2'd1;
            fill_n     = ALIGNED;
          end
        end
        default: begin
          // Lower half closes the pending split instruction
          if (rsp_i.word[17:16] == 2'b11) begin
            n_incoming = 2'd1;
          end else begin
            n_incoming = 2'd2;
            fill_n     = ALIGNED;
          end
        end
      endcase
    end
  end

  assign instr_cnt_n = ctrl_i.redirect ? '0 :
                       instr_cnt_q + ICNT_W'(n_incoming) - ICNT_W'(pop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
      instr_cnt_q   <= '0;
      pop_q         <= 1'b0;
      fill_q        <= ALIGNED;
      fetch_addr_q  <= '0;
    end else begin
      outstanding_q <= outstanding_n;
      flush_q       <= flush_n;
      instr_cnt_q   <= instr_cnt_n;
      pop_q         <= pop_i;
      fill_q        <= fill_n;
      // Sequential fetch address follows the last request made
      if (ctrl_i.redirect) begin
        fetch_addr_q <= req_fire ? target_word + 32'd4 : target_word;
      end else if (req_fire) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
    end
  end

endmodule

/* align_buffer/instr_aligner.sv */
`timescale 1ns/1ns

module instr_aligner (
  input  logic                      clk,
  input  logic                      rst_n,
  input  align_pkg::align_ctrl_t    ctrl_i,
  input  fetch_bus_pkg::fetch_rsp_t rsp_i,
  input  logic                      accept_i,
  input  fetch_bus_pkg::word_t      head_i,
  input  logic                      head_valid_i,
  input  fetch_bus_pkg::word_t      next_i,
  input  logic                      next_valid_i,
  output align_pkg::instr_out_t     instr_o,
  input  logic                      instr_ready_i,
  output logic                      pop_o,
  output logic                      advance_o
);

  import fetch_bus_pkg::*;
  import align_pkg::*;

  addr_t addr_q, addr_n;
  addr_t word_next;
  word_t aligned_word;
  half_t upper_half;
  half_t second_half;
  logic  any_valid;
  logic  split_valid;
  logic  aligned_is_c;
  logic  unaligned_is_c;

  ////////////////////////////////////////////////////////////
  // Source selection
  // Aligned data sits in the head entry, else comes straight from memory
  assign aligned_word = head_valid_i ? head_i : rsp_i.word;
  assign upper_half   = aligned_word[31:16];
  // Second half of a split instruction
  assign second_half  = next_valid_i ? next_i[15:0] : rsp_i.word[15:0];

  assign any_valid   = head_valid_i || accept_i;
  // Head alone cannot hold both halves of a split instruction
  assign split_valid = next_valid_i || (head_valid_i && accept_i);

  // Only meaningful while any_valid is high
  assign aligned_is_c   = aligned_word[1:0] != 2'b11;
  assign unaligned_is_c = aligned_word[17:16] != 2'b11;

  ////////////////////////////////////////////////////////////
  // Output to decode
  always_comb begin
    instr_o.addr  = addr_q;
    instr_o.instr = aligned_word;
    instr_o.valid = any_valid;
    if (addr_q[1]) begin
      instr_o.instr = {second_half, upper_half};
      instr_o.valid = unaligned_is_c ? any_valid : split_valid;
    end
    // Buffered words are stale once a redirect is seen
    if (ctrl_i.redirect) begin
      instr_o.valid = 1'b0;
    end
  end

  assign pop_o = instr_o.valid && instr_ready_i;

  ////////////////////////////////////////////////////////////
  // Address stepping
  assign word_next = {addr_q[31:2], 2'b00} + 32'd4;

  always_comb begin
    if (addr_q[1]) begin
      // Unaligned, always leaves the head word
      addr_n = unaligned_is_c ? word_next : {word_next[31:2], 2'b10};
    end else begin
      addr_n = aligned_is_c ? {addr_q[31:2], 2'b10} : word_next;
    end
  end

  // Head is used up unless an aligned compressed one leaves its upper half
  assign advance_o = pop_o && (addr_q[1] || !aligned_is_c);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (ctrl_i.redirect) begin
      addr_q <= ctrl_i.redirect_addr;
    end else if (pop_o) begin
      addr_q <= addr_n;
    end
  end

endmodule

/* align_buffer/word_store.sv */
`timescale 1ns/1ns
`include "align_params.svh"

module word_store (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      redirect_i,
  input  fetch_bus_pkg::fetch_rsp_t rsp_i,
  input  logic                      accept_i,
  input  logic                      advance_i,
  output fetch_bus_pkg::word_t      head_o,
  output logic                      head_valid_o,
  output fetch_bus_pkg::word_t      next_o,
  output logic                      next_valid_o
);

  import fetch_bus_pkg::*;

  localparam int unsigned PTR_W = $clog2(`ALIGN_DEPTH);

  word_t                 mem_q [`ALIGN_DEPTH];
  logic [`ALIGN_DEPTH-1:0] valid_q, valid_n;
  logic [PTR_W-1:0]      wptr_q, rptr_q;
  logic [PTR_W-1:0]      wptr_inc, rptr_inc;

  ////////////////////////////////////////////////////////////
  // Pointer stepping with wrap at the last entry
  assign wptr_inc = (wptr_q == PTR_W'(`ALIGN_DEPTH - 1)) ? '0 : wptr_q + PTR_W'(1);
  assign rptr_inc = (rptr_q == PTR_W'(`ALIGN_DEPTH - 1)) ? '0 : rptr_q + PTR_W'(1);

  // Head and the entry behind it
  assign head_o       = mem_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_o       = mem_q[rptr_inc];
  assign next_valid_o = valid_q[rptr_inc];

  always_comb begin
    valid_n = valid_q;
    // Set before clear, a word consumed through the bypass never stays valid
    if (accept_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (advance_i) begin
      valid_n[rptr_q] = 1'b0;
    end
    if (redirect_i) begin
      valid_n = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (redirect_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (accept_i) begin
          wptr_q <= wptr_inc;
        end
        if (advance_i) begin
          rptr_q <= rptr_inc;
        end
      end
    end
  end

  // Word payload
  always_ff @(posedge clk) begin
    if (accept_i) begin
      mem_q[wptr_q] <= rsp_i.word;
    end
  end

endmodule

/* common/align_params.svh */
`ifndef ALIGN_PARAMS_SVH
`define ALIGN_PARAMS_SVH

// Word entries held in the alignment store
`define ALIGN_DEPTH 3

// Maximum number of requests in flight towards memory
`define ALIGN_CREDITS 2

// Memory word and instruction parcel widths
`define ALIGN_WORD_W 32
`define ALIGN_HALF_W 16

`endif

/* common/align_pkg.sv */
`include "align_params.svh"

// Instruction side of the alignment buffer
package align_pkg;

  // One 16-bit instruction parcel
  typedef logic [`ALIGN_HALF_W-1:0] half_t;

  // Instruction container, upper half unused when compressed
  typedef logic [`ALIGN_WORD_W-1:0] instr_t;

  // Instruction handed to decode
  typedef struct packed {
    logic                 valid;
    instr_t               instr;
    fetch_bus_pkg::addr_t addr;
  } instr_out_t;

  // Controller inputs
  typedef struct packed {
    logic                 fetch_enable;
    // Clears buffered state and restarts at redirect_addr
    logic                 redirect;
    fetch_bus_pkg::addr_t redirect_addr;
  } align_ctrl_t;

  // Position of the write side relative to instruction boundaries
  typedef enum logic [1:0] {
    ALIGNED,
    UNALIGNED_SKIP,
    UNALIGNED_PART
  } fill_state_e;

endpackage

/* common/fetch_bus_pkg.sv */
`include "align_params.svh"

// Memory side of the fetch path
package fetch_bus_pkg;

  // One aligned memory word
  typedef logic [`ALIGN_WORD_W-1:0] word_t;

  // Byte address, same width as a word on this core
  typedef logic [`ALIGN_WORD_W-1:0] addr_t;

  // Request towards instruction memory
  typedef struct packed {
    logic  valid;
    // Marks the first request of a new stream
    logic  branch;
    // Always word aligned
    addr_t addr;
  } fetch_req_t;

  // Response from instruction memory, in request order
  typedef struct packed {
    logic  valid;
    word_t word;
  } fetch_rsp_t;

endpackage

/* dv/align_assertions.sv */
`timescale 1ns/1ns
`include "align_params.svh"

module align_assertions #(
  parameter bit CREDIT_CHECKS = 1'b0,
  parameter bit OUTPUT_CHECKS = 1'b0
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [$clog2(`ALIGN_CREDITS + 1)-1:0] outstanding_i,
  input  align_pkg::instr_out_t                 instr_i,
  input  logic                                  instr_ready_i,
  input  logic                                  redirect_i,
  input  logic                                  accept_i
);

  // Failed checks so far, read by the testbench
  int unsigned err_cnt = 0;

  ////////////////////////////////////////////////////////////
  // Request side
  if (CREDIT_CHECKS) begin : g_credit
    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding_i <= `ALIGN_CREDITS)
    else begin
      $error("outstanding requests above the credit limit");
      err_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode side
  if (OUTPUT_CHECKS) begin : g_output
    // Upper half of a compressed instruction carries no meaning
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      (instr_i.valid && !instr_ready_i) |=> redirect_i ||
      ($stable(instr_i.valid) && $stable(instr_i.addr) && $stable(instr_i.instr[15:0]) &&
       ((instr_i.instr[1:0] != 2'b11) || $stable(instr_i.instr[31:16]))))
    else begin
      $error("instruction changed while stalled by decode");
      err_cnt++;
    end

    // Store is empty after a redirect, only the bypass can feed decode
    bypass_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
      redirect_i |=> (!instr_i.valid || accept_i))
    else begin
      $error("instruction valid after redirect without an accepted word");
      err_cnt++;
    end
  end

endmodule

/* dv/align_tb.sv */
`timescale 1ns/1ns
`include "align_params.svh"

module align_tb;

  import fetch_bus_pkg::*;
  import align_pkg::*;

  // Program image in halfwords that wraps at the top
  localparam int unsigned MEM_HALVES = 4096;
  localparam int unsigned HALF_MASK  = MEM_HALVES - 1;
  // Instructions checked per phase
  localparam int unsigned N_SEQ      = 150;
  localparam int unsigned N_REDIR    = 80;
  localparam int unsigned N_STALL    = 120;
  localparam int unsigned N_RESUME   = 50;
  localparam int unsigned N_TOTAL    = N_SEQ + N_REDIR + N_STALL + N_RESUME;
  localparam int unsigned CLK_NS     = 100;
  // About 20 cycles per instruction
  localparam longint unsigned WATCHDOG_NS = longint'(N_TOTAL) * 20 * CLK_NS;

  logic        clk;
  logic        rst_n;
  align_ctrl_t ctrl;
  fetch_req_t  req;
  logic        req_ready;
  fetch_rsp_t  rsp;
  instr_out_t  instr;
  logic        instr_ready;

  half_t       prog_mem [MEM_HALVES];
  // Requests waiting for their response slot
  addr_t       pend_addr [$];
  longint      pend_due [$];
  longint      cyc;
  longint      last_due;
  int          outs;
  int unsigned pop_count;
  addr_t       exp_addr;
  logic        stall_mode;

  align_buffer_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl),
    .req_o         (req),
    .req_ready_i   (req_ready),
    .rsp_i         (rsp),
    .instr_o       (instr),
    .instr_ready_i (instr_ready)
  );

  bind fetch_credit_ctrl align_assertions #(.CREDIT_CHECKS(1'b1)) credit_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .outstanding_i (outstanding_q),
    .instr_i       ('0),
    .instr_ready_i (1'b0),
    .redirect_i    (1'b0),
    .accept_i      (1'b0)
  );

  bind instr_aligner align_assertions #(.OUTPUT_CHECKS(1'b1)) output_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .outstanding_i ('0),
    .instr_i       (instr_o),
    .instr_ready_i (instr_ready_i),
    .redirect_i    (ctrl_i.redirect),
    .accept_i      (accept_i)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      stop_with_failure($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h",
                                  $time, what, actual, expected));
    end
  endtask

  function automatic int unsigned assert_errors();
    return dut0.credit0.credit_chk.err_cnt + dut0.aligner0.output_chk.err_cnt;
  endfunction

  // Aligned memory word as two consecutive parcels
  function automatic word_t mem_word(input addr_t a);
    int unsigned idx;
    idx = (a >> 1) & HALF_MASK;
    return {prog_mem[(idx + 1) & HALF_MASK], prog_mem[idx]};
  endfunction

  // Expected instruction at a byte address and its length in bytes
  function automatic instr_t ref_instr(input addr_t a, output int unsigned len);
    int unsigned idx;
    half_t       lo;
    idx = (a >> 1) & HALF_MASK;
    lo  = prog_mem[idx];
    // Low bits 11 open a 32-bit instruction
    if (lo[1:0] == 2'b11) begin
      len = 4;
      return {prog_mem[(idx + 1) & HALF_MASK], lo};
    end
    len = 2;
    return {16'h0000, lo};
  endfunction

  task automatic wait_for_pops(input int unsigned n);
    int unsigned target;
    target = pop_count + n;
    while (pop_count < target) begin
      @(negedge clk);
    end
  endtask

  // One-cycle redirect that also restarts the scoreboard at the target
  task automatic redirect_to(input addr_t target);
    ctrl.fetch_enable  = 1'b1;
    ctrl.redirect      = 1'b1;
    ctrl.redirect_addr = target;
    exp_addr           = target;
    @(negedge clk);
    ctrl.redirect      = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Timeout: the run did not finish within the watchdog limit");
  end

  ////////////////////////////////////////////////////////////
  // Memory model with in-order replies after 1 to 3 cycles
  initial begin
    longint due;
    req_ready = 1'b0;
    rsp       = '0;
    cyc       = 0;
    last_due  = 0;
    outs      = 0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (req.valid && req_ready) begin
          check_eq(32'(req.addr[1:0]), 32'd0, "request address alignment");
          check_eq(32'(req.branch), 32'(ctrl.redirect), "request branch flag");
          due = cyc + longint'($urandom_range(1, 3));
          // Keep one reply per cycle and request order
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          pend_addr.push_back(req.addr);
          pend_due.push_back(due);
          outs++;
        end
        if (rsp.valid) begin
          outs--;
        end
        check_eq(32'(outs <= `ALIGN_CREDITS), 32'd1, "outstanding requests within two");
      end
      @(negedge clk);
      cyc++;
      rsp = '0;
      if ((pend_due.size() != 0) && (pend_due[0] <= cyc)) begin
        rsp.valid = 1'b1;
        rsp.word  = mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      req_ready = ($urandom_range(0, 3) != 0);
    end
  end

  // Decode back-pressure
  always @(negedge clk) begin
    if (stall_mode) begin
      instr_ready = ($urandom_range(0, 1) != 0);
    end else begin
      instr_ready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparator with one check per pop
  always @(posedge clk) begin
    instr_t      exp_instr;
    int unsigned len;
    if (rst_n && instr.valid && instr_ready) begin
      exp_instr = ref_instr(exp_addr, len);
      check_eq(instr.addr, exp_addr, "instruction address");
      if (len == 4) begin
        check_eq(instr.instr, exp_instr, "32-bit instruction");
      end else begin
        check_eq(32'(instr.instr[15:0]), exp_instr, "compressed instruction");
      end
      exp_addr  = exp_addr + len;
      pop_count = pop_count + 1;
    end
  end

  always @(negedge clk) begin
    if (assert_errors() != 0) begin
      stop_with_failure("A bound assertion failed inside the DUT");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  initial begin
    int unsigned k;
    half_t       h;
    void'($urandom(32'h5a6d));
    rst_n       = 1'b0;
    ctrl        = '0;
    instr_ready = 1'b0;
    stall_mode  = 1'b0;
    pop_count   = 0;
    exp_addr    = '0;
    // About half of the parcels open a 32-bit instruction
    for (k = 0; k < MEM_HALVES; k++) begin
      h = half_t'($urandom);
      if ($urandom_range(0, 1) == 1) begin
        h[1:0] = 2'b11;
      end else if (h[1:0] == 2'b11) begin
        h[1:0] = 2'b01;
      end
      prog_mem[k] = h;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    // Idle after reset
    @(posedge clk);
    check_eq(32'(req.valid), 32'd0, "request valid after reset");
    check_eq(32'(instr.valid), 32'd0, "instruction valid after reset");
    @(negedge clk);

    // Sequential stream from a word boundary
    redirect_to(32'h0000_0100);
    wait_for_pops(N_SEQ);

    // Halfword target with both requests still in flight
    while (outs < `ALIGN_CREDITS) begin
      @(negedge clk);
    end
    redirect_to(32'h0000_0a02);
    wait_for_pops(N_REDIR);

    // Random decode stalls
    stall_mode = 1'b1;
    wait_for_pops(N_STALL);
    stall_mode = 1'b0;

    // No requests once fetch is off and drained
    ctrl.fetch_enable = 1'b0;
    while (outs != 0) begin
      @(negedge clk);
    end
    repeat (20) begin
      @(posedge clk);
      check_eq(32'(req.valid), 32'd0, "request while fetch disabled");
    end
    @(negedge clk);
    redirect_to(32'h0000_1406);
    wait_for_pops(N_RESUME);
    repeat (4) @(negedge clk);

    if (assert_errors() == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_failure("Bound assertions reported errors");
    end
  end

endmodule

/* sources.f */
+incdir+common
common/fetch_bus_pkg.sv
common/align_pkg.sv
align_buffer/fetch_credit_ctrl.sv
align_buffer/word_store.sv
align_buffer/instr_aligner.sv
align_buffer/align_buffer_top.sv
dv/align_assertions.sv
dv/align_tb.sv
